//--- exec_isa_pkg.sv
package exec_isa_pkg;

  localparam logic [31:0] RESET_VECTOR     = 32'hffffffc0;
  localparam logic [31:0] TRAP_BASE_OFFSET = 32'h60;
  localparam int          INT_STALL_CYCLES = 4;

  typedef enum logic [3:0] {
    T_INH    = 4'h0,
    T_CMP    = 4'h3,
    T_MOV    = 4'h4,
    T_INTU   = 4'h5,
    T_ALU    = 4'h6,
    T_INT    = 4'h7,
    T_LDI    = 4'h8,
    T_LOAD   = 4'h9,
    T_STORE  = 4'ha,
    T_BRANCH = 4'hb,
    T_JUMP   = 4'hc
  } itype_t;

  // the third register field shares its bits with imm
  typedef struct packed {
    logic [31:0] ext;   // extension word, address or value
    itype_t      itype;
    logic [3:0]  op;
    logic [7:0]  regs;
    logic [14:0] imm;
    logic        size;  // ext present or trap/setvec variant
  } instr_t;

  typedef struct packed {
    logic [31:0] result;
    logic [31:0] reg_data1;
    logic [1:0]  reg_write;
  } ex_result_t;

  typedef struct packed {
    logic [31:0] pc;
    logic        pc_set;
  } branch_t;

endpackage

//--- exec_alu_pkg.sv
package exec_alu_pkg;

  typedef enum logic [2:0] {
    ALU_AND = 3'h0,
    ALU_OR  = 3'h1,
    ALU_ADD = 3'h2,
    ALU_SUB = 3'h3,
    ALU_LSL = 3'h4,
    ALU_ASR = 3'h5,
    ALU_LSR = 3'h6,
    ALU_XOR = 3'h7
  } alufunc_t;

  // bit 3 selects the unsigned variant
  typedef enum logic [3:0] {
    INT_MUL   = 4'h0,
    INT_MULX  = 4'h1,
    INT_DIV   = 4'h2,
    INT_MOD   = 4'h3,
    INT_MULU  = 4'h8,
    INT_MULXU = 4'h9,
    INT_DIVU  = 4'ha,
    INT_MODU  = 4'hb
  } intfunc_t;

  typedef struct packed {
    logic c;
    logic n;
    logic v;
    logic z;
  } alu_flags_t;

  typedef struct packed {
    logic ltu;
    logic lt;
    logic eq;
  } ccr_t;

endpackage

//--- alu_comb.sv
`timescale 1ns/10ps

module alu_comb (
  input  logic [31:0]              in1_i,
  input  logic [31:0]              in2_i,
  input  exec_alu_pkg::alufunc_t   func_i,
  output logic [31:0]              out_o,
  output exec_alu_pkg::alu_flags_t flags_o
);
  import exec_alu_pkg::*;

  logic        is_sub;
  logic [32:0] sum;
  logic        ovf_add;
  logic        ovf_sub;

  assign is_sub = (func_i == ALU_SUB);

  // bit 32 is carry on add, borrow on subtract
  assign sum = is_sub ? ({1'b0, in1_i} - {1'b0, in2_i}) : ({1'b0, in1_i} + {1'b0, in2_i});

  assign ovf_add = (in1_i[31] == in2_i[31]) && (sum[31] != in1_i[31]);
  assign ovf_sub = (in1_i[31] != in2_i[31]) && (sum[31] != in1_i[31]);

  always_comb
  begin
    case (func_i)
      ALU_AND: out_o = in1_i & in2_i;
      ALU_OR:  out_o = in1_i | in2_i;
      ALU_ADD: out_o = sum[31:0];
      ALU_SUB: out_o = sum[31:0];
      ALU_LSL: out_o = in1_i << in2_i[4:0];
      ALU_ASR: out_o = $unsigned($signed(in1_i) >>> in2_i[4:0]);
      ALU_LSR: out_o = in1_i >> in2_i[4:0];
      ALU_XOR: out_o = in1_i ^ in2_i;
      default: out_o = 32'h0;
    endcase
  end

  always_comb
  begin
    flags_o.c = sum[32];
    flags_o.v = is_sub ? ovf_sub : ovf_add;
    flags_o.n = out_o[31];
    flags_o.z = (out_o == 32'h0);
  end

endmodule

//--- int_calc.sv
`timescale 1ns/10ps

module int_calc (
  input  logic [31:0]            in1_i,
  input  logic [31:0]            in2_i,
  input  exec_alu_pkg::intfunc_t func_i,
  output logic [31:0]            out_o
);
  import exec_alu_pkg::*;

  logic        is_unsigned;
  logic [63:0] ext1;
  logic [63:0] ext2;
  logic [63:0] prod;
  logic [31:0] quot;
  logic [31:0] rem;

  assign is_unsigned = func_i[3];

  // low 64 bits of the extended product are right for both signednesses
  assign ext1 = is_unsigned ? {32'h0, in1_i} : {{32{in1_i[31]}}, in1_i};
  assign ext2 = is_unsigned ? {32'h0, in2_i} : {{32{in2_i[31]}}, in2_i};
  assign prod = ext1 * ext2;

  always_comb
  begin
    if (in2_i == 32'h0)
    begin
      quot = '1; // divide by zero
      rem  = '1;
    end
    else if (is_unsigned)
    begin
      quot = in1_i / in2_i;
      rem  = in1_i % in2_i;
    end
    else
    begin
      quot = $unsigned($signed(in1_i) / $signed(in2_i));
      rem  = $unsigned($signed(in1_i) % $signed(in2_i));
    end
  end

  always_comb
  begin
    case (func_i)
      INT_MUL, INT_MULU:   out_o = prod[31:0];
      INT_MULX, INT_MULXU: out_o = prod[63:32];
      INT_DIV, INT_DIVU:   out_o = quot;
      INT_MOD, INT_MODU:   out_o = rem;
      default:             out_o = 32'h0;
    endcase
  end

endmodule

//--- execute.sv
`timescale 1ns/10ps

module execute (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  exec_isa_pkg::instr_t     ir_i,
  input  logic [31:0]              pc_i,
  input  logic [31:0]              reg_data1_i,
  input  logic [31:0]              reg_data2_i,
  input  logic [1:0]               reg_write_i,
  input  logic                     stall_i,
  output exec_isa_pkg::ex_result_t ex_o,
  output exec_isa_pkg::instr_t     ir_o,
  output exec_isa_pkg::branch_t    br_o,
  output exec_alu_pkg::ccr_t       ccr_o,
  output logic                     halt_o,
  output logic                     exc_o,
  output logic                     int_en_o,
  output logic                     stall_o
);
  import exec_isa_pkg::*;
  import exec_alu_pkg::*;

  localparam int CNT_W = $clog2(INT_STALL_CYCLES + 1);

  logic [31:0]      sval;
  logic [31:0]      aligned_imm;
  logic [31:0]      alu_in1;
  logic [31:0]      alu_in2;
  logic [31:0]      alu_out;
  logic [31:0]      int_out;
  alufunc_t         alu_func;
  intfunc_t         int_func;
  alu_flags_t       flags;
  logic             is_int;
  logic             stall_start;
  logic             advance;
  logic             take;
  logic [CNT_W-1:0] delay;
  logic [31:0]      vec_base;
  ex_result_t       ex_next;
  branch_t          br_next;
  ccr_t             ccr_next;
  logic             exc_next;

  assign sval        = {{17{ir_i.imm[14]}}, ir_i.imm};
  assign aligned_imm = {sval[29:0], 2'b00};

  assign is_int      = (ir_i.itype == T_INT) || (ir_i.itype == T_INTU);
  assign stall_start = is_int && (delay == '0);
  assign stall_o     = stall_start || (delay > CNT_W'(1));
  assign advance     = !(stall_i || stall_o);

  always_comb
  begin
    alu_in1  = reg_data1_i;
    alu_in2  = reg_data2_i;
    alu_func = alufunc_t'(ir_i.op[2:0]);
    int_func = intfunc_t'({ir_i.itype == T_INTU, ir_i.op[2:0]});
    case (ir_i.itype)
      T_ALU, T_INT:
        if (ir_i.op[3])
          alu_in2 = sval;
      T_CMP:
        alu_func = ALU_SUB;
      T_LOAD, T_STORE:
      begin
        alu_func = ALU_ADD;
        alu_in1  = aligned_imm; // plus reg_data2
      end
      T_BRANCH:
      begin
        alu_func = ALU_ADD;
        alu_in1  = pc_i;
        alu_in2  = aligned_imm;
      end
      T_JUMP:
      begin
        alu_func = ALU_ADD;
        alu_in2  = aligned_imm;
      end
      default: ;
    endcase
  end

  alu_comb alu_comb_inst (
    .in1_i   (alu_in1),
    .in2_i   (alu_in2),
    .func_i  (alu_func),
    .out_o   (alu_out),
    .flags_o (flags)
  );

  int_calc int_calc_inst (
    .in1_i  (alu_in1),
    .in2_i  (alu_in2),
    .func_i (int_func),
    .out_o  (int_out)
  );

  always_comb
  begin
    case (ir_i.op)
      4'h0:    take = 1'b1;                       // bra
      4'h1:    take = ccr_o.eq;
      4'h2:    take = !ccr_o.eq;
      4'h3:    take = !(ccr_o.ltu || ccr_o.eq);   // gtu
      4'h4:    take = !(ccr_o.lt || ccr_o.eq);    // gt
      4'h5:    take = !ccr_o.lt;                  // ge
      4'h6:    take = ccr_o.lt || ccr_o.eq;       // le
      4'h7:    take = ccr_o.lt;
      4'h8:    take = !ccr_o.ltu;                 // geu
      4'h9:    take = ccr_o.ltu;
      4'ha:    take = ccr_o.ltu || ccr_o.eq;      // leu
      default: take = 1'b0;
    endcase
  end

  always_comb
  begin
    br_next.pc     = pc_i;
    br_next.pc_set = 1'b0;
    if (ir_i.itype == T_BRANCH && take)
    begin
      br_next.pc     = alu_out;
      br_next.pc_set = 1'b1;
    end
    else if (ir_i.itype == T_JUMP)
    begin
      br_next.pc     = ir_i.size ? ir_i.ext : alu_out;
      br_next.pc_set = 1'b1;
    end
  end

  always_comb
  begin
    ex_next.reg_data1 = reg_data1_i;
    ex_next.reg_write = reg_write_i;
    exc_next          = 1'b0;
    case (ir_i.itype)
      T_INH:
        if (ir_i.op == 4'h5)
        begin
          ex_next.result = vec_base; // reset vector
          exc_next       = 1'b1;
        end
        else if (ir_i.op == 4'h1 && !ir_i.size)
        begin
          ex_next.result = vec_base + TRAP_BASE_OFFSET + {27'h0, ir_i.imm[1:0], 3'b000};
          exc_next       = 1'b1;
        end
        else
          ex_next.result = alu_out;
      T_INT, T_INTU:
        ex_next.result = int_out;
      T_LOAD, T_STORE:
        ex_next.result = ir_i.size ? ir_i.ext : alu_out;
      T_LDI:
        ex_next.result = ir_i.size ? ir_i.ext : {17'h0, ir_i.imm};
      T_MOV:
        ex_next.result = reg_data1_i;
      default:
        ex_next.result = alu_out;
    endcase
  end

  assign ccr_next = (ir_i.itype == T_CMP) ? {flags.c, flags.n ^ flags.v, flags.z} : ccr_o;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      delay <= '0;
    else if (stall_start)
      delay <= CNT_W'(INT_STALL_CYCLES);
    else if (delay != '0 && !(delay == CNT_W'(1) && stall_i))
      delay <= delay - CNT_W'(1); // last count waits for stall_i
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ex_o  <= '0;
      ir_o  <= '0;
      br_o  <= '0;
      ccr_o <= '0;
      exc_o <= 1'b0;
    end
    else if (advance)
    begin
      ex_o  <= ex_next;
      ir_o  <= ir_i;
      br_o  <= br_next;
      ccr_o <= ccr_next;
      exc_o <= exc_next;
    end
    else
    begin
      br_o.pc_set <= 1'b0; // pulses last one cycle
      exc_o       <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      vec_base <= RESET_VECTOR;
      int_en_o <= 1'b0;
      halt_o   <= 1'b0;
    end
    else if (advance && ir_i.itype == T_INH)
    begin
      case (ir_i.op)
        4'h1:
          if (ir_i.size)
            vec_base <= ir_i.ext; // setvec
        4'h2: int_en_o <= 1'b0;  // cli
        4'h3: int_en_o <= 1'b1;  // sti
        4'h4: halt_o   <= 1'b1;  // held until reset
        default: ;
      endcase
    end
  end

endmodule

//--- execute_properties.sv
`timescale 1ns/10ps

module execute_properties (
  input logic clk_i,
  input logic rst_i,
  input logic stall_o,
  input logic halt_o,
  input logic exc_o
);

  int stall_run; // consecutive cycles with stall_o high

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      stall_run <= 0;
    else if (stall_o)
      stall_run <= stall_run + 1;
    else
      stall_run <= 0;
  end

  stall_len_a: assert property (@(posedge clk_i) disable iff (rst_i) stall_run <= 4)
    else $error("stall_o high for more than 4 cycles");

  halt_hold_a: assert property (@(posedge clk_i) disable iff (rst_i) !$fell(halt_o))
    else $error("halt_o fell without reset");

  exc_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i) exc_o |=> !exc_o)
    else $error("exc_o high for more than one cycle");

endmodule

bind execute execute_properties execute_properties_inst (.*);

//--- execute_tb.sv
`timescale 1ns/10ps

module execute_tb;
  import exec_isa_pkg::*;
  import exec_alu_pkg::*;

  typedef struct packed {
    instr_t      ir;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic        hold;   // row driven with stall_i high
    ex_result_t  ex;
    branch_t     br;
    ccr_t        ccr;
    logic        exc;
    logic        halt;
    logic        int_en;
  } row_t;

  localparam logic [1:0] WR = 2'b10;

  logic clk_i = 1'b0;
  logic rst_i;
  instr_t ir_i;
  logic [31:0] pc_i, reg_data1_i, reg_data2_i;
  logic [1:0] reg_write_i;
  logic stall_i;
  ex_result_t ex_o;
  instr_t ir_o;
  branch_t br_o;
  ccr_t ccr_o;
  logic halt_o, exc_o, int_en_o, stall_o;

  row_t table_q[$];
  row_t last;
  ccr_t m_ccr = '0;
  logic m_int = 1'b0;
  logic m_halt = 1'b0;
  integer seed = 12433;
  int cycles = 0;
  int limit = 1000;

  execute execute_inst (.*);

  always #2 clk_i = !clk_i;

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("timeout: run did not finish within %0d cycles", limit);
      stop_on_error();
    end
  end

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_result(input ex_result_t got, input ex_result_t exp);
    if (got !== exp)
    begin
      $display("ERROR ex_o got %h expected %h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_ir(input instr_t got, input instr_t exp);
    if (got !== exp)
    begin
      $display("ERROR ir_o got %h expected %h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_branch(input branch_t got, input branch_t exp);
    if (got !== exp)
    begin
      $display("ERROR br_o got %h expected %h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_ccr(input ccr_t got, input ccr_t exp);
    if (got !== exp)
    begin
      $display("ERROR ccr_o got %h expected %h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  function automatic instr_t mk(itype_t t, logic [3:0] op, logic [14:0] imm, logic size,
                                logic [31:0] ext);
    instr_t ir;
    ir = '0;
    ir.itype = t;
    ir.op = op;
    ir.imm = imm;
    ir.size = size;
    ir.ext = ext;
    return ir;
  endfunction

  // branch condition from the condition code, ops in listed order
  function automatic logic cond_holds(logic [3:0] op, ccr_t c);
    case (op)
      4'h0: return 1'b1;
      4'h1: return c.eq;
      4'h2: return !c.eq;
      4'h3: return !c.ltu && !c.eq;
      4'h4: return !c.lt && !c.eq;
      4'h5: return !c.lt;
      4'h6: return c.lt || c.eq;
      4'h7: return c.lt;
      4'h8: return !c.ltu;
      4'h9: return c.ltu;
      4'ha: return c.ltu || c.eq;
      default: return 1'b0;
    endcase
  endfunction

  task automatic add(input instr_t ir, input logic [31:0] pc, input logic [31:0] a,
                     input logic [31:0] b, input logic [31:0] result, input logic exc);
    row_t r;
    r = '0;
    r.ir = ir;
    r.pc = pc;
    r.a = a;
    r.b = b;
    r.ex = {result, a, WR};
    r.br = {pc, 1'b0};
    if (ir.itype == T_JUMP)
      r.br = {ir.size ? ir.ext : result, 1'b1};
    else if (ir.itype == T_BRANCH && cond_holds(ir.op, m_ccr))
      r.br = {result, 1'b1};
    if (ir.itype == T_CMP)
      m_ccr = {a < b, $signed(a) < $signed(b), a == b};
    if (ir.itype == T_INH && ir.op == 4'h2)
      m_int = 1'b0;
    if (ir.itype == T_INH && ir.op == 4'h3)
      m_int = 1'b1;
    if (ir.itype == T_INH && ir.op == 4'h4)
      m_halt = 1'b1;
    r.ccr = m_ccr;
    r.exc = exc;
    r.halt = m_halt;
    r.int_en = m_int;
    table_q.push_back(r);
    last = r;
  endtask

  // new instruction under stall_i, outputs must keep the last row's values
  task automatic add_hold(input instr_t ir, input logic [31:0] a, input logic [31:0] b);
    row_t r;
    r = last;
    r.ir = ir;
    r.a = a;
    r.b = b;
    r.hold = 1'b1;
    r.br.pc_set = 1'b0;
    r.exc = 1'b0;
    table_q.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] a, b;
    logic [63:0] ps, pu;
    a = $random(seed);
    b = $random(seed);
    add(mk(T_INH, 4'h5, 15'h0, 1'b0, 0), 32'h100, 0, 0, 32'hffffffc0, 1'b1);
    add(mk(T_ALU, 4'h2, 15'h0, 1'b0, 0), 32'h104, a, b, a + b, 1'b0);
    add(mk(T_ALU, 4'hb, 15'h7ff0, 1'b0, 0), 32'h108, a, b, a + 32'h10, 1'b0);
    add(mk(T_ALU, 4'h0, 15'h0, 1'b0, 0), 32'h10c, a, b, a & b, 1'b0);
    add(mk(T_ALU, 4'h1, 15'h0, 1'b0, 0), 32'h10c, a, b, a | b, 1'b0);
    add(mk(T_ALU, 4'h7, 15'h0, 1'b0, 0), 32'h110, a, b, a ^ b, 1'b0);
    add(mk(T_ALU, 4'h4, 15'h0, 1'b0, 0), 32'h114, a, b, a << b[4:0], 1'b0);
    add(mk(T_ALU, 4'hd, 15'h5, 1'b0, 0), 32'h118, a, b, 32'($signed(a) >>> 5), 1'b0);
    add(mk(T_ALU, 4'h6, 15'h0, 1'b0, 0), 32'h11c, a, b, a >> b[4:0], 1'b0);
    add(mk(T_CMP, 4'h0, 15'h0, 1'b0, 0), 32'h120, a, b, a - b, 1'b0);
    add_hold(mk(T_CMP, 4'h0, 15'h0, 1'b0, 0), b, b);
    for (int op = 0; op < 11; op++)
      add(mk(T_BRANCH, 4'(op), 15'h7ffe, 1'b0, 0), 32'h1000, a, b, 32'h0ff8, 1'b0);
    add(mk(T_CMP, 4'h0, 15'h0, 1'b0, 0), 32'h124, b, b, 32'h0, 1'b0);
    for (int op = 1; op < 11; op += 3)
      add(mk(T_BRANCH, 4'(op), 15'h4, 1'b0, 0), 32'h2000, a, b, 32'h2010, 1'b0);
    add(mk(T_JUMP, 4'h0, 15'h4, 1'b1, 32'h20000040), 32'h128, a, b, a + 32'h10, 1'b0);
    add(mk(T_JUMP, 4'h0, 15'h4, 1'b0, 0), 32'h12c, a, b, a + 32'h10, 1'b0);
    add(mk(T_LOAD, 4'h0, 15'h3, 1'b0, 0), 32'h130, a, b, b + 32'hc, 1'b0);
    add(mk(T_STORE, 4'h0, 15'h3, 1'b1, 32'h1234abcd), 32'h134, a, b, 32'h1234abcd, 1'b0);
    add(mk(T_LDI, 4'h0, 15'h5a5a, 1'b0, 0), 32'h138, a, b, 32'h5a5a, 1'b0);
    add(mk(T_MOV, 4'h0, 15'h0, 1'b0, 0), 32'h13c, a, b, a, 1'b0);
    b = b | 32'h1; // keep divisor nonzero
    ps = $signed(a) * $signed(b);
    pu = {32'h0, a} * {32'h0, b};
    add(mk(T_INT, 4'h0, 15'h0, 1'b0, 0), 32'h140, a, b, ps[31:0], 1'b0);
    add(mk(T_INT, 4'h1, 15'h0, 1'b0, 0), 32'h144, a, b, ps[63:32], 1'b0);
    add(mk(T_INT, 4'h2, 15'h0, 1'b0, 0), 32'h148, a, b, 32'($signed(a) / $signed(b)), 1'b0);
    add(mk(T_INT, 4'h3, 15'h0, 1'b0, 0), 32'h14c, a, b, 32'($signed(a) % $signed(b)), 1'b0);
    add(mk(T_INTU, 4'h0, 15'h0, 1'b0, 0), 32'h150, a, b, pu[31:0], 1'b0);
    add(mk(T_INTU, 4'h1, 15'h0, 1'b0, 0), 32'h154, a, b, pu[63:32], 1'b0);
    add(mk(T_INTU, 4'h2, 15'h0, 1'b0, 0), 32'h158, a, b, a / b, 1'b0);
    add(mk(T_INTU, 4'h3, 15'h0, 1'b0, 0), 32'h15c, a, b, a % b, 1'b0);
    add(mk(T_INT, 4'h2, 15'h0, 1'b0, 0), 32'h160, a, 0, 32'hffffffff, 1'b0);
    add(mk(T_INTU, 4'h3, 15'h0, 1'b0, 0), 32'h164, a, 0, 32'hffffffff, 1'b0);
    // system ops with zero operands, so the ALU side result is zero
    add(mk(T_INH, 4'h1, 15'h0, 1'b1, 32'h8000), 32'h168, 0, 0, 0, 1'b0);
    add(mk(T_INH, 4'h1, 15'h2, 1'b0, 0), 32'h16c, 0, 0, 32'h8070, 1'b1);
    add(mk(T_INH, 4'h3, 15'h0, 1'b0, 0), 32'h170, 0, 0, 0, 1'b0);
    add(mk(T_INH, 4'h2, 15'h0, 1'b0, 0), 32'h174, 0, 0, 0, 1'b0);
    add(mk(T_INH, 4'h3, 15'h0, 1'b0, 0), 32'h178, 0, 0, 0, 1'b0);
    add(mk(T_INH, 4'h4, 15'h0, 1'b0, 0), 32'h17c, 0, 0, 0, 1'b0);
    add(mk(T_MOV, 4'h0, 15'h0, 1'b0, 0), 32'h180, a, b, a, 1'b0);
  endtask

  initial
  begin
    int n;
    logic is_int;
    instr_t exp_ir;
    rst_i = 1'b1;
    ir_i = '0;
    pc_i = '0;
    reg_data1_i = '0;
    reg_data2_i = '0;
    reg_write_i = '0;
    stall_i = 1'b0;
    exp_ir = '0;
    build_table();
    limit = table_q.size() * 8 + 40;
    repeat (8) @(posedge clk_i);
    #0.5 rst_i = 1'b0;
    check_result(ex_o, '0);
    check_ir(ir_o, '0);
    check_branch(br_o, '0);
    check_ccr(ccr_o, '0);
    check_bit("halt_o", halt_o, 1'b0);
    check_bit("exc_o", exc_o, 1'b0);
    check_bit("int_en_o", int_en_o, 1'b0);
    check_bit("stall_o", stall_o, 1'b0);
    foreach (table_q[i])
    begin
      ir_i = table_q[i].ir;
      pc_i = table_q[i].pc;
      reg_data1_i = table_q[i].a;
      reg_data2_i = table_q[i].b;
      reg_write_i = WR;
      stall_i = table_q[i].hold;
      is_int = (table_q[i].ir.itype == T_INT) || (table_q[i].ir.itype == T_INTU);
      if (!table_q[i].hold)
        exp_ir = table_q[i].ir; // held rows keep the previous instruction
      n = 0;
      @(negedge clk_i);
      while (stall_o)
      begin
        n++;
        @(negedge clk_i);
      end
      if (n != (is_int ? INT_STALL_CYCLES : 0))
      begin
        $display("row %0d: stall_o was high for %0d cycles instead of the expected count", i, n);
        stop_on_error();
      end
      @(posedge clk_i);
      #0.5;
      check_result(ex_o, table_q[i].ex);
      check_ir(ir_o, exp_ir);
      check_branch(br_o, table_q[i].br);
      check_ccr(ccr_o, table_q[i].ccr);
      check_bit("exc_o", exc_o, table_q[i].exc);
      check_bit("halt_o", halt_o, table_q[i].halt);
      check_bit("int_en_o", int_en_o, table_q[i].int_en);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- sim.f
exec_isa_pkg.sv
exec_alu_pkg.sv
alu_comb.sv
int_calc.sv
execute.sv
execute_properties.sv
execute_tb.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module execute_tb -f sim.f -o execute_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/execute_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
